// File: Makefile
TOOL     = verilator
TOP      = nabp_filtered_buffer_tb
FILELIST = nabp_filtered_buffer.f
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "all tests passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: nabp_filtered_buffer.f
+incdir+src
src/nabp_data_pkg.sv
src/nabp_ctrl_pkg.sv
src/ramp_fir.sv
src/filtered_ram_swappable.sv
src/filtered_ram_swap_control.sv
src/projection_scan.sv
src/nabp_filtered_buffer.sv
tests/nabp_filtered_buffer_props.sv
tests/nabp_filtered_buffer_tb.sv

// File: src/filtered_ram_swap_control.sv
`timescale 1ns/1ps
`include "nabp_cfg.svh"

module filtered_ram_swap_control (
    input  logic                   clk,
    input  logic                   reset_n,
    input  nabp_data_pkg::angle_t  hs_angle,
    input  logic                   hs_has_next_angle,
    input  logic                   hs_next_angle_ack,
    input  nabp_data_pkg::filt_t   hs_val,
    input  nabp_data_pkg::s_addr_t pr0_s_val,
    input  nabp_data_pkg::s_addr_t pr1_s_val,
    input  logic                   pr_next_angle,
    output nabp_data_pkg::s_addr_t hs_s_val,
    output logic                   hs_next_angle,
    output logic                   fir_clear,
    output nabp_data_pkg::angle_t  pr_angle,
    output logic                   pr_has_next_angle,
    output logic                   pr_next_angle_ack,
    output nabp_data_pkg::filt_t   pr0_val,
    output nabp_data_pkg::filt_t   pr1_val
);
    import nabp_data_pkg::*;
    import nabp_ctrl_pkg::*;

    swap_state_t state;
    swap_state_t next_state;
    swap_sel_t   sw_sel;

    // angle currently filling and whether more follow it
    angle_t      fill_angle;
    logic        fill_has_next;

    logic        filling;
    logic        swap_curr;
    logic        swap_prev;
    logic        swap;
    logic        fill_kick;
    logic        kick_idx;
    logic        fill_done;
    logic        swap_ready;

    // per swappable wiring
    logic        sw_kick      [2];
    logic        sw_fill_done [2];
    s_addr_t     sw_hs_s_val  [2];
    filt_t       sw_pr0_val   [2];
    filt_t       sw_pr1_val   [2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // swappables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < 2; i++)
    begin : g_sw
        filtered_ram_swappable i_sw (
            .clk       (clk),
            .reset_n   (reset_n),
            .fill_kick (sw_kick[i]),
            .hs_val    (hs_val),
            .pr0_s_val (pr0_s_val),
            .pr1_s_val (pr1_s_val),
            .fill_done (sw_fill_done[i]),
            .hs_s_val  (sw_hs_s_val[i]),
            .pr0_val   (sw_pr0_val[i]),
            .pr1_val   (sw_pr1_val[i])
        );
        assign sw_kick[i] = fill_kick && (kick_idx == 1'(i));
    end

    // filling side is ~sw_sel, working side is sw_sel
    assign fill_done = sw_sel ? sw_fill_done[0] : sw_fill_done[1];
    assign hs_s_val  = sw_sel ? sw_hs_s_val[0]  : sw_hs_s_val[1];
    assign pr0_val   = sw_sel ? sw_pr0_val[1]   : sw_pr0_val[0];
    assign pr1_val   = sw_sel ? sw_pr1_val[1]   : sw_pr1_val[0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // swap decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign filling    = (state == fill_s) || (state == fill_and_work_s);
    // filled RAM is complete and the scan is free for it
    assign swap_ready = fill_done && pr_next_angle;

    // swap on host ack while more angles follow, else on ready alone
    assign swap_curr = filling &&
                       (fill_has_next ? hs_next_angle_ack : swap_ready);
    assign swap      = swap_curr && !swap_prev;

    assign hs_next_angle = (state == ready_s) ||
                           (filling && fill_has_next && swap_ready);

    // first fill in ready, refill of the old working RAM on a swap
    assign fill_kick = ((state == ready_s) && hs_next_angle_ack) ||
                       (swap && fill_has_next);
    // sw_sel has not toggled yet during a swap
    assign kick_idx  = (state == ready_s) ? !sw_sel : sw_sel;
    assign fir_clear = fill_kick;

    assign pr_next_angle_ack = swap;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state     <= ready_s;
            sw_sel    <= 1'b0;
            swap_prev <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            swap_prev <= swap_curr;
            if (swap)
                sw_sel <= !sw_sel;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (hs_next_angle_ack)
                    next_state = fill_s;
            fill_s, fill_and_work_s:
                if (swap)
                    next_state = fill_has_next ? fill_and_work_s : work_s;
            work_s:
                // scan finished the last angle
                if (pr_next_angle)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // angle bookkeeping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (fill_kick)
        begin
            fill_angle    <= hs_angle;
            fill_has_next <= hs_has_next_angle;
        end
        if (swap)
            pr_angle <= fill_angle;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pr_has_next_angle <= 1'b0;
        else if (swap)
            pr_has_next_angle <= fill_has_next;
    end

endmodule

// File: src/filtered_ram_swappable.sv
`timescale 1ns/1ps
`include "nabp_cfg.svh"

module filtered_ram_swappable (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   fill_kick,
    input  nabp_data_pkg::filt_t   hs_val,
    input  nabp_data_pkg::s_addr_t pr0_s_val,
    input  nabp_data_pkg::s_addr_t pr1_s_val,
    output logic                   fill_done,
    output nabp_data_pkg::s_addr_t hs_s_val,
    output nabp_data_pkg::filt_t   pr0_val,
    output nabp_data_pkg::filt_t   pr1_val
);
    import nabp_data_pkg::*;

    localparam int LAT = `NABP_FIR_LAT;

    // fill address generator
    logic    fill_active;
    s_addr_t fill_cnt;
    logic    fill_last;

    // address, enable and last flag delayed to meet the filtered data
    s_addr_t wr_addr_d [LAT];
    logic    wr_en_d   [LAT];
    logic    wr_last_d [LAT];

    // filtered samples of one angle
    filt_t   mem [`NABP_DEPTH];

    assign hs_s_val  = fill_cnt;
    assign fill_last = (fill_cnt == s_addr_t'(`NABP_DEPTH - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host address counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_active <= 1'b0;
            fill_cnt    <= '0;
        end
        else if (fill_kick)
        begin
            // first address goes out the cycle after the kick
            fill_active <= 1'b1;
            fill_cnt    <= '0;
        end
        else if (fill_active)
        begin
            if (fill_last)
                fill_active <= 1'b0;
            else
                fill_cnt <= fill_cnt + s_addr_t'(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alignment delay
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < LAT; i++)
            begin
                wr_en_d[i]   <= 1'b0;
                wr_last_d[i] <= 1'b0;
            end
        end
        else
        begin
            wr_en_d[0]   <= fill_active;
            wr_last_d[0] <= fill_active && fill_last;
            for (int i = 1; i < LAT; i++)
            begin
                wr_en_d[i]   <= wr_en_d[i-1];
                wr_last_d[i] <= wr_last_d[i-1];
            end
        end
    end

    // address stages, same depth as the enable
    always_ff @(posedge clk)
    begin
        wr_addr_d[0] <= fill_cnt;
        for (int i = 1; i < LAT; i++)
            wr_addr_d[i] <= wr_addr_d[i-1];
    end

    // done level, held until the next kick
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            fill_done <= 1'b0;
        else if (fill_kick)
            fill_done <= 1'b0;
        else if (wr_en_d[LAT-1] && wr_last_d[LAT-1])
            fill_done <= 1'b1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one write port, two read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (wr_en_d[LAT-1])
            mem[wr_addr_d[LAT-1]] <= hs_val;
    end

    // registered reads, 1 cycle latency
    always_ff @(posedge clk)
    begin
        pr0_val <= mem[pr0_s_val];
        pr1_val <= mem[pr1_s_val];
    end

endmodule

// File: src/nabp_cfg.svh
`ifndef NABP_CFG_SVH
`define NABP_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// angle tag carried with each sample pair
`define NABP_ANGLE_W 8
// sample address, covers NABP_DEPTH
`define NABP_S_W 6
// samples per angle
`define NABP_DEPTH 64
// raw host samples, unsigned
`define NABP_RAW_W 10
// filtered samples, signed
`define NABP_FILT_W 12

// host address to filtered value
// 1 cycle host RAM read + 1 cycle FIR register
`define NABP_FIR_LAT 2

`endif

// File: src/nabp_ctrl_pkg.sv
package nabp_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // swap control types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // ready: idle, waiting for the first angle
    // fill: first angle filling, nothing to work on
    // fill_and_work: one RAM fills while the other is scanned
    // work: last angle being scanned, nothing filling
    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_and_work_s,
        work_s
    } swap_state_t;

    // 0 -> RAM 0 working, RAM 1 filling
    typedef logic swap_sel_t;

endpackage

// File: src/nabp_data_pkg.sv
`include "nabp_cfg.svh"

package nabp_data_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data path types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // projection angle index
    typedef logic [`NABP_ANGLE_W-1:0] angle_t;

    // sample address within one angle
    typedef logic [`NABP_S_W-1:0] s_addr_t;

    // raw sample from the host RAM
    typedef logic [`NABP_RAW_W-1:0] raw_t;

    // ramp filtered sample, can go negative
    typedef logic signed [`NABP_FILT_W-1:0] filt_t;

endpackage

// File: src/nabp_filtered_buffer.sv
`timescale 1ns/1ps
`include "nabp_cfg.svh"

module nabp_filtered_buffer (
    input  logic                   clk,
    input  logic                   reset_n,
    // host angle handshake
    input  nabp_data_pkg::angle_t  hs_angle,
    input  logic                   hs_has_next_angle,
    input  logic                   hs_next_angle_ack,
    output logic                   hs_next_angle,
    // host projection RAM
    output nabp_data_pkg::s_addr_t hs_s_val,
    input  nabp_data_pkg::raw_t    hs_raw,
    // sample pair stream
    output logic                   out_valid,
    input  logic                   out_ready,
    output nabp_data_pkg::angle_t  out_angle,
    output nabp_data_pkg::s_addr_t out_s0,
    output nabp_data_pkg::filt_t   out_val0,
    output nabp_data_pkg::s_addr_t out_s1,
    output nabp_data_pkg::filt_t   out_val1
);
    import nabp_data_pkg::*;

    // FIR to filling RAM
    filt_t   hs_val;
    logic    fir_clear;

    // working RAM to scan
    angle_t  pr_angle;
    logic    pr_has_next_angle;
    logic    pr_next_angle;
    logic    pr_next_angle_ack;
    s_addr_t pr0_s_val;
    s_addr_t pr1_s_val;
    filt_t   pr0_val;
    filt_t   pr1_val;

    ramp_fir i_fir (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (fir_clear),
        .in_val  (hs_raw),
        .out_val (hs_val)
    );

    filtered_ram_swap_control i_swap (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_val            (hs_val),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .hs_s_val          (hs_s_val),
        .hs_next_angle     (hs_next_angle),
        .fir_clear         (fir_clear),
        .pr_angle          (pr_angle),
        .pr_has_next_angle (pr_has_next_angle),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val)
    );

    projection_scan i_scan (
        .clk               (clk),
        .reset_n           (reset_n),
        .pr_angle          (pr_angle),
        .pr_has_next_angle (pr_has_next_angle),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val),
        .out_ready         (out_ready),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .out_valid         (out_valid),
        .out_angle         (out_angle),
        .out_s0            (out_s0),
        .out_s1            (out_s1),
        .out_val0          (out_val0),
        .out_val1          (out_val1)
    );

endmodule

// File: src/projection_scan.sv
`timescale 1ns/1ps
`include "nabp_cfg.svh"

module projection_scan (
    input  logic                   clk,
    input  logic                   reset_n,
    input  nabp_data_pkg::angle_t  pr_angle,
    input  logic                   pr_has_next_angle,
    input  logic                   pr_next_angle_ack,
    input  nabp_data_pkg::filt_t   pr0_val,
    input  nabp_data_pkg::filt_t   pr1_val,
    input  logic                   out_ready,
    output nabp_data_pkg::s_addr_t pr0_s_val,
    output nabp_data_pkg::s_addr_t pr1_s_val,
    output logic                   pr_next_angle,
    output logic                   out_valid,
    output nabp_data_pkg::angle_t  out_angle,
    output nabp_data_pkg::s_addr_t out_s0,
    output nabp_data_pkg::s_addr_t out_s1,
    output nabp_data_pkg::filt_t   out_val0,
    output nabp_data_pkg::filt_t   out_val1
);
    import nabp_data_pkg::*;

    localparam int HW = `NABP_S_W - 1;

    // sweep position within each half
    logic [HW-1:0] cnt;
    logic [HW-1:0] rd_idx;
    logic          sweeping;
    logic          rd_pending;
    // finished with more to come / finished the sequence
    logic          done_r;
    logic          idle_r;

    logic          stage_free;
    logic          issue;
    logic          last_xfer;

    assign pr0_s_val     = {1'b0, cnt};
    assign pr1_s_val     = {1'b1, cnt};
    assign pr_next_angle = done_r || idle_r;

    // stage empty or emptying this cycle
    assign stage_free = !out_valid || out_ready;
    // one read in flight at most, so the stage can always take it
    assign issue      = sweeping && !rd_pending && stage_free;
    assign last_xfer  = !pr_next_angle && !sweeping && !rd_pending &&
                        out_valid && out_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sweep control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt        <= '0;
            sweeping   <= 1'b0;
            rd_pending <= 1'b0;
            out_valid  <= 1'b0;
            done_r     <= 1'b0;
            idle_r     <= 1'b1;
        end
        else
        begin
            rd_pending <= issue;
            if (pr_next_angle_ack)
            begin
                sweeping <= 1'b1;
                cnt      <= '0;
                done_r   <= 1'b0;
                idle_r   <= 1'b0;
            end
            else if (issue)
            begin
                cnt <= cnt + 1'b1;
                if (&cnt)
                    sweeping <= 1'b0;
            end
            // read data lands in the stage
            if (rd_pending)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
            if (last_xfer)
            begin
                done_r <= pr_has_next_angle;
                idle_r <= !pr_has_next_angle;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stage payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (issue)
            rd_idx <= cnt;
        // only loads when the stage is free, so it holds under back-pressure
        if (rd_pending)
        begin
            out_angle <= pr_angle;
            out_s0    <= {1'b0, rd_idx};
            out_s1    <= {1'b1, rd_idx};
            out_val0  <= pr0_val;
            out_val1  <= pr1_val;
        end
    end

endmodule

// File: src/ramp_fir.sv
`timescale 1ns/1ps
`include "nabp_cfg.svh"

module ramp_fir (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  clear,
    input  nabp_data_pkg::raw_t   in_val,
    output nabp_data_pkg::filt_t  out_val
);
    import nabp_data_pkg::*;

    // x[s-1], x[s-2]
    raw_t       hist1;
    raw_t       hist2;
    // cycles to ignore after clear, the host RAM read is still in flight
    logic [1:0] skip;

    // taps widened to the signed output width
    filt_t      tap0;
    filt_t      tap1;
    filt_t      tap2;

    assign tap0 = filt_t'({{(`NABP_FILT_W-`NABP_RAW_W){1'b0}}, in_val});
    assign tap1 = filt_t'({{(`NABP_FILT_W-`NABP_RAW_W){1'b0}}, hist1});
    assign tap2 = filt_t'({{(`NABP_FILT_W-`NABP_RAW_W){1'b0}}, hist2});

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // history
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            hist1 <= '0;
            hist2 <= '0;
            skip  <= '0;
        end
        else if (clear)
        begin
            // new angle starts from zeros
            hist1 <= '0;
            hist2 <= '0;
            skip  <= 2'(`NABP_FIR_LAT - 1);
        end
        else if (skip != 2'd0)
        begin
            // sample on the bus belongs to no address yet
            skip <= skip - 2'd1;
        end
        else
        begin
            hist1 <= in_val;
            hist2 <= hist1;
        end
    end

    // ramp kernel -1, 2, -1
    always_ff @(posedge clk)
    begin
        out_val <= (tap1 <<< 1) - tap0 - tap2;
    end

endmodule

// File: tests/nabp_filtered_buffer_props.sv
`timescale 1ns/1ps

module nabp_filtered_buffer_props (
    input logic                   clk,
    input logic                   reset_n,
    input logic                   hs_next_angle,
    input logic                   hs_next_angle_ack,
    input logic                   out_valid,
    input logic                   out_ready,
    input nabp_data_pkg::angle_t  out_angle,
    input nabp_data_pkg::s_addr_t out_s0,
    input nabp_data_pkg::s_addr_t out_s1,
    input nabp_data_pkg::filt_t   out_val0,
    input nabp_data_pkg::filt_t   out_val1
);
    // failures so far, read back by the testbench
    int fail_cnt = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ack_needs_request: assert property (@(posedge clk) disable iff (!reset_n)
        hs_next_angle_ack |-> hs_next_angle)
    else
    begin
        $error("host ack seen while hs_next_angle is low");
        fail_cnt++;
    end

    // request withdrawn once the host has acked
    request_drops_after_ack: assert property (@(posedge clk) disable iff (!reset_n)
        hs_next_angle_ack |=> !hs_next_angle)
    else
    begin
        $error("hs_next_angle still high the cycle after the host ack");
        fail_cnt++;
    end

    // ready for an angle straight out of reset, stream still empty
    request_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |-> hs_next_angle && !out_valid)
    else
    begin
        $error("no angle request or stream not empty after reset");
        fail_cnt++;
    end

    no_output_in_reset: assert property (@(posedge clk)
        !reset_n |=> !out_valid)
    else
    begin
        $error("out_valid high after a reset cycle");
        fail_cnt++;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    hold_under_backpressure: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_angle) &&
            $stable(out_s0) && $stable(out_s1) &&
            $stable(out_val0) && $stable(out_val1))
    else
    begin
        $error("output stream changed while stalled");
        fail_cnt++;
    end

endmodule

bind nabp_filtered_buffer nabp_filtered_buffer_props i_props (
    .clk               (clk),
    .reset_n           (reset_n),
    .hs_next_angle     (hs_next_angle),
    .hs_next_angle_ack (hs_next_angle_ack),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .out_angle         (out_angle),
    .out_s0            (out_s0),
    .out_s1            (out_s1),
    .out_val0          (out_val0),
    .out_val1          (out_val1)
);

// File: tests/nabp_filtered_buffer_tb.sv
`timescale 1ns/1ps
`include "nabp_cfg.svh"

module nabp_filtered_buffer_tb;
    import nabp_data_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int N_ANGLES        = 9;
    localparam int HALF            = `NABP_DEPTH / 2;
    localparam int WATCHDOG_CYCLES = N_ANGLES * 200 + 100;

    logic        clk = 1'b0;
    logic        reset_n;
    angle_t      hs_angle;
    logic        hs_has_next_angle;
    logic        hs_next_angle_ack;
    logic        hs_next_angle;
    s_addr_t     hs_s_val;
    raw_t        hs_raw;
    logic        out_valid;
    logic        out_ready;
    angle_t      out_angle;
    s_addr_t     out_s0;
    s_addr_t     out_s1;
    filt_t       out_val0;
    filt_t       out_val1;

    // raw samples per angle, host side
    raw_t        raw_tab [N_ANGLES][`NABP_DEPTH];
    angle_t      ang_val [N_ANGLES];
    logic [31:0] lcg_state = 32'h1264_5b54;
    // angle being filled and its address of the previous cycle
    int          fill_k = 0;
    s_addr_t     host_addr = '0;
    // angles acked, angles fully output, pairs of the current angle
    int          n_acked = 0;
    int          out_k = 0;
    int          pair_cnt = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    nabp_filtered_buffer i_dut (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_next_angle     (hs_next_angle),
        .hs_s_val          (hs_s_val),
        .hs_raw            (hs_raw),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_angle         (out_angle),
        .out_s0            (out_s0),
        .out_val0          (out_val0),
        .out_s1            (out_s1),
        .out_val1          (out_val1)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ramp kernel -1, 2, -1 with zeros before sample 0
    function automatic int ramp_ref(input int k, input int s);
        int acc;
        acc = -int'(raw_tab[k][s]);
        if (s >= 1)
            acc += 2 * int'(raw_tab[k][s-1]);
        if (s >= 2)
            acc -= int'(raw_tab[k][s-2]);
        return acc;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // one pair leaving at the coming rising edge
    task automatic check_pair();
        int s;
        s = pair_cnt;
        if (out_k >= n_acked)
        begin
            $display("a pair was output with no angle outstanding");
            errors++;
            return;
        end
        check_field("out_angle", out_angle, ang_val[out_k]);
        check_field("out_s0", out_s0, s);
        check_field("out_s1", out_s1, s + HALF);
        check_field("out_val0", out_val0, ramp_ref(out_k, s));
        check_field("out_val1", out_val1, ramp_ref(out_k, s + HALF));
        pair_cnt++;
        if (pair_cnt == HALF)
        begin
            pair_cnt = 0;
            out_k++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: %0d errors", name, errors - err0);
            tests_failed++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host RAM and stream sink
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk)
    begin : host_and_sink
        logic [31:0] r;
        // ready about three cycles in four, sampled at the coming edge
        r = next_rand();
        out_ready = (r[31:30] != 2'b00);
        // pair transfers at that same edge
        if (reset_n && out_valid && out_ready)
            check_pair();
        // data follows its address by one cycle
        hs_raw = raw_tab[fill_k][host_addr];
        host_addr = hs_s_val;
    end

    // host answers a request, a short delay varying per angle
    task automatic send_angle(input int k, input logic more, input logic first);
        repeat (k % 3) @(negedge clk);
        while (!hs_next_angle)
            @(negedge clk);
        // previous angle of the sequence still has pairs to output
        if (!first)
        begin
            assert (out_k < k)
            else
            begin
                $display("angle %0d was requested only after angle %0d was fully output",
                         k, k - 1);
                errors++;
            end
        end
        hs_angle          = ang_val[k];
        hs_has_next_angle = more;
        hs_next_angle_ack = 1'b1;
        fill_k            = k;
        n_acked++;
        @(negedge clk);
        hs_next_angle_ack = 1'b0;
        // request withdrawn once accepted
        check_field("hs_next_angle", hs_next_angle, 1'b0);
    endtask

    task automatic run_sequence(input string name, input int first, input int count);
        int err0;
        err0 = errors;
        for (int k = first; k < first + count; k++)
            send_angle(k, k < first + count - 1, k == first);
        wait (out_k == first + count);
        // last angle out, the host is asked again
        while (!hs_next_angle)
            @(negedge clk);
        check_field("out_valid", out_valid, 1'b0);
        assert (out_k == first + count && pair_cnt == 0)
        else
        begin
            $display("sequence ended after %0d angles and %0d extra pairs", out_k, pair_cnt);
            errors++;
        end
        report_test(name, err0);
    endtask

    task automatic check_reset();
        int err0;
        err0 = errors;
        reset_n = 1'b0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_field("hs_next_angle", hs_next_angle, 1'b1);
        check_field("out_valid", out_valid, 1'b0);
        report_test("reset and first request", err0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        int err0;
        logic [31:0] r;
        reset_n           = 1'b0;
        hs_angle          = '0;
        hs_has_next_angle = 1'b0;
        hs_next_angle_ack = 1'b0;
        hs_raw            = '0;
        out_ready         = 1'b0;
        for (int k = 0; k < N_ANGLES; k++)
        begin
            ang_val[k] = angle_t'(k * 29 + 5);
            for (int s = 0; s < `NABP_DEPTH; s++)
            begin
                r = next_rand();
                raw_tab[k][s] = r[25:16];
            end
        end
        check_reset();
        run_sequence("five angles", 0, 5);
        run_sequence("three angles", 5, 3);
        run_sequence("single angle", 8, 1);
        err0 = errors;
        if (i_dut.i_props.fail_cnt != 0)
        begin
            $display("protocol assertions failed %0d times", i_dut.i_props.fail_cnt);
            errors++;
        end
        report_test("protocol assertions", err0);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // run length bound from the number of angles
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule
